// File: tb.f
+incdir+.
usb_loop_pkg.sv
sync_fifo.sv
bulk_ready_flags.sv
usb_status_leds.sv
bulk_loopback_top.sv
tb_clock_gen.sv
bulk_loopback_tb.sv

// File: bulk_loopback_tb.sv
`timescale 1ns/10ps
`include "usb_loop_macros.svh"

module bulk_loopback_tb;

  typedef enum {mode_loop, mode_flags, mode_hold, mode_full, mode_status, mode_sof} test_mode_t;

  typedef struct {
    string      name;
    test_mode_t mode;
    int         len;
    int         ready_pct;
    int         blk_pct;
    logic       cfg;
    logic       exp_in;
    logic       exp_out;
  } test_row_t;

  localparam int num_rows   = 9;
  localparam int fifo_depth = 1 << `FIFO_ABITS;

  logic       usb_clock;
  logic       usb_reset;
  logic       reset_req;
  logic       s_valid;
  logic       s_ready;
  logic       s_last;
  logic [7:0] s_data;
  logic       m_valid;
  logic       m_ready;
  logic       m_last;
  logic [7:0] m_data;
  logic       configured;
  logic       blk_cycle;
  logic       sof;
  logic       crc_err;
  logic       timeout;
  logic       blk_in_ready;
  logic       blk_out_ready;
  logic [5:0] leds;

  test_row_t rows [num_rows];
  test_row_t row;
  string     cur_name = "reset";
  int        error_count = 0;
  int        errors_before;
  int        tests_failed = 0;
  int        cycle_count = 0;
  int        cycle_limit = 20000;
  int        sof_edges;

  usb_loop_pkg::bulk_beat_t tx_q[$];
  usb_loop_pkg::bulk_beat_t model_q[$];

  tb_clock_gen u_clock_gen (
    .usb_clock  (usb_clock),
    .usb_reset  (usb_reset),
    .reset_req_i(reset_req)
  );

  bulk_loopback_top bulk_loopback_top_inst (
    .usb_clock(usb_clock), .usb_reset(usb_reset),
    .s_valid_i(s_valid), .s_ready_o(s_ready), .s_last_i(s_last), .s_data_i(s_data),
    .m_valid_o(m_valid), .m_ready_i(m_ready), .m_last_o(m_last), .m_data_o(m_data),
    .configured_i(configured), .blk_cycle_i(blk_cycle), .sof_i(sof),
    .crc_err_i(crc_err), .timeout_i(timeout),
    .blk_in_ready_o(blk_in_ready), .blk_out_ready_o(blk_out_ready), .leds_o(leds)
  );

  task automatic check_value(string what, logic [31:0] exp_val, logic [31:0] act_val);
    assert (exp_val === act_val) else begin
      $display("FAILED %s %s: expected %0h, actual %0h", cur_name, what, exp_val, act_val);
      error_count++;
    end
  endtask

  // Random packets of 1 to 64 bytes, last set on each final byte
  task automatic make_beats(int n);
    int plen;
    tx_q.delete();
    while (tx_q.size() < n) begin
      plen = 1 + ($urandom % 64);
      if (plen > n - tx_q.size()) begin
        plen = n - tx_q.size();
      end
      for (int i = 0; i < plen; i++) begin
        tx_q.push_back({(i == plen - 1), 8'($urandom)});
      end
    end
  endtask

  // Offer beats in order, each held until the DUT takes it
  task automatic send_beats(int n, int ready_pct, int blk_pct);
    int sent;
    sent = 0;
    while (sent < n) begin
      s_valid   <= 1'b1;
      s_last    <= tx_q[sent].last;
      s_data    <= tx_q[sent].data;
      blk_cycle <= ($urandom % 100) < blk_pct;
      m_ready   <= ($urandom % 100) < ready_pct;
      @(posedge usb_clock);
      if (s_valid && s_ready && blk_cycle) begin
        sent++;
      end
    end
    s_valid <= 1'b0;
  endtask

  task automatic stall_reads(int cycles);
    s_valid   <= 1'b0;
    m_ready   <= 1'b0;
    blk_cycle <= 1'b1;
    repeat (cycles) @(posedge usb_clock);
  endtask

  // Read until nothing is left and the model has been empty for 3 cycles
  task automatic drain_fifo();
    int idle;
    idle = 0;
    s_valid   <= 1'b0;
    m_ready   <= 1'b1;
    blk_cycle <= 1'b1;
    while (idle < 3) begin
      @(posedge usb_clock);
      idle = (model_q.size() == 0 && !m_valid) ? idle + 1 : 0;
    end
  endtask

  task automatic pulse_status(bit is_crc);
    if (is_crc) crc_err <= 1'b1;
    else timeout <= 1'b1;
    @(posedge usb_clock);
    crc_err <= 1'b0;
    timeout <= 1'b0;
    repeat (3) @(posedge usb_clock);
  endtask

  task automatic check_sticky();
    pulse_status(1'b1);
    check_value("leds_o[3] after crc", 1'b0, leds[3]);
    pulse_status(1'b0);
    check_value("leds_o[4] after timeout", 1'b0, leds[4]);
    repeat (20) @(posedge usb_clock);
    check_value("leds_o[4:3] held", 2'b00, leds[4:3]);
    reset_req <= 1'b1;
    repeat (2) @(posedge usb_clock);
    reset_req <= 1'b0;
    repeat (5) @(posedge usb_clock);
    check_value("leds_o[4:3] after reset", 2'b11, leds[4:3]);
  endtask

  // Two-cycle sof pulses, one low cycle between them
  task automatic sof_pulses(int count);
    repeat (count) begin
      sof <= 1'b1;
      repeat (2) @(posedge usb_clock);
      sof <= 1'b0;
      @(posedge usb_clock);
      sof_edges++;
    end
    repeat (4) @(posedge usb_clock);
    check_value("leds_o[5]", !sof_edges[`BLINK_BIT], leds[5]);
  endtask

  // Reference queue model of every accepted beat
  always @(posedge usb_clock) begin
    usb_loop_pkg::bulk_beat_t exp_beat;
    if (!usb_reset) begin
      if (s_valid && s_ready && blk_cycle) begin
        model_q.push_back({s_last, s_data});
      end
      if (m_valid && m_ready && blk_cycle) begin
        assert (model_q.size() > 0) else begin
          $display("FAILED %s: IN beat returned with no OUT beat outstanding", cur_name);
          error_count++;
        end
        if (model_q.size() > 0) begin
          exp_beat = model_q.pop_front();
          check_value("IN beat", exp_beat, {m_last, m_data});
        end
      end
      check_value("leds_o[1:0]", 2'b11, leds[1:0]);
    end
  end

  always @(posedge usb_clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout in test %s after %0d cycles, DUT stopped making progress",
               cur_name, cycle_count);
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'hddc46c9d));
    rows[0] = '{"loopback", mode_loop, 400, 100, 100, 1'b1, 1'b0, 1'b1};
    rows[1] = '{"backpressure", mode_loop, 400, 50, 60, 1'b1, 1'b0, 1'b1};
    rows[2] = '{"flags_unconfigured", mode_flags, 0, 0, 0, 1'b0, 1'b0, 1'b0};
    rows[3] = '{"flags_drained", mode_flags, 0, 0, 0, 1'b1, 1'b0, 1'b1};
    rows[4] = '{"flags_in_ready", mode_hold, `IN_READY_MIN + 1, 0, 100, 1'b1, 1'b1, 1'b1};
    rows[5] = '{"flags_out_full", mode_hold, `OUT_READY_MAX, 0, 100, 1'b1, 1'b1, 1'b0};
    rows[6] = '{"fifo_full", mode_full, fifo_depth, 0, 100, 1'b1, 1'b1, 1'b0};
    rows[7] = '{"sticky_status", mode_status, 0, 0, 0, 1'b1, 1'b0, 1'b1};
    rows[8] = '{"sof_blink", mode_sof, 8192, 0, 0, 1'b1, 1'b0, 1'b1};
    for (int r = 0; r < num_rows; r++) begin
      cycle_limit += rows[r].len * 4;
    end
    reset_req  <= 1'b0;
    s_valid    <= 1'b0;
    s_last     <= 1'b0;
    s_data     <= '0;
    m_ready    <= 1'b0;
    configured <= 1'b0;
    blk_cycle  <= 1'b0;
    sof        <= 1'b0;
    crc_err    <= 1'b0;
    timeout    <= 1'b0;
    sof_edges  = 0;
    while (usb_reset) @(posedge usb_clock);

    for (int r = 0; r < num_rows; r++) begin
      row = rows[r];
      cur_name = row.name;
      errors_before = error_count;
      configured <= row.cfg;
      if (row.mode == mode_hold || row.mode == mode_full) begin
        make_beats(row.len);
        send_beats(row.len, row.ready_pct, row.blk_pct);
        stall_reads(3);
        if (row.mode == mode_full) begin
          // One more beat offered to a full FIFO must be refused
          s_valid <= 1'b1;
          repeat (2) @(posedge usb_clock);
          s_valid <= 1'b0;
          @(posedge usb_clock);
          check_value("s_ready_o when full", 1'b0, s_ready);
          check_value("beats accepted", fifo_depth, model_q.size());
        end
        check_value("blk_in_ready_o", row.exp_in, blk_in_ready);
        check_value("blk_out_ready_o", row.exp_out, blk_out_ready);
        // Activity LED is on, driven low, while either flag is up
        check_value("leds_o[2]", !(row.exp_in || row.exp_out), leds[2]);
        drain_fifo();
      end else begin
        case (row.mode)
          mode_loop: begin
            make_beats(row.len);
            send_beats(row.len, row.ready_pct, row.blk_pct);
          end
          mode_status: check_sticky();
          mode_sof: begin
            sof_pulses(row.len / 2);
            sof_pulses(row.len / 2);
          end
          default: ;
        endcase
        drain_fifo();
        check_value("blk_in_ready_o", row.exp_in, blk_in_ready);
        check_value("blk_out_ready_o", row.exp_out, blk_out_ready);
        check_value("leds_o[2]", !(row.exp_in || row.exp_out), leds[2]);
      end
      if (error_count == errors_before) begin
        $display("test %s: ok", cur_name);
      end else begin
        $display("test %s: %0d errors", cur_name, error_count - errors_before);
        tests_failed++;
      end
    end

    $display("Tests run %0d, passed %0d, failed %0d, check errors %0d",
             num_rows, num_rows - tests_failed, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
  output logic usb_clock,
  output logic usb_reset,
  input  logic reset_req_i
);

  int reset_cycles = 0;

  // 20 ns period
  initial begin
    usb_clock = 1'b0;
    forever #10 usb_clock = ~usb_clock;
  end

  // Power-on reset for 8 cycles, later only on request
  initial usb_reset = 1'b1;

  always @(posedge usb_clock) begin
    if (reset_cycles < 8) begin
      reset_cycles <= reset_cycles + 1;
    end
    usb_reset <= (reset_cycles < 7) || reset_req_i;
  end

endmodule

// File: bulk_loopback_top.sv
`timescale 1ns/10ps

module bulk_loopback_top (
  input  logic                    usb_clock,
  input  logic                    usb_reset,

  // OUT stream from the core
  input  logic                    s_valid_i,
  output logic                    s_ready_o,
  input  logic                    s_last_i,
  input  usb_loop_pkg::usb_byte_t s_data_i,

  // IN stream to the core
  output logic                    m_valid_o,
  input  logic                    m_ready_i,
  output logic                    m_last_o,
  output usb_loop_pkg::usb_byte_t m_data_o,

  // Core status
  input  logic                    configured_i,
  input  logic                    blk_cycle_i,
  input  logic                    sof_i,
  input  logic                    crc_err_i,
  input  logic                    timeout_i,

  output logic                    blk_in_ready_o,
  output logic                    blk_out_ready_o,
  output logic [5:0]              leds_o
);

  usb_loop_pkg::bulk_beat_t  wr_beat;
  usb_loop_pkg::bulk_beat_t  rd_beat;
  usb_loop_pkg::fifo_level_t fifo_level;
  logic                      fifo_wr_valid;
  logic                      fifo_rd_ready;
  logic                      bulk_activity;

  // Transfers only count inside a bulk cycle
  assign fifo_wr_valid = s_valid_i && blk_cycle_i;
  assign fifo_rd_ready = m_ready_i && blk_cycle_i;

  assign wr_beat  = '{last: s_last_i, data: s_data_i};
  assign m_last_o = rd_beat.last;
  assign m_data_o = rd_beat.data;

  sync_fifo #(
    .payload_t(usb_loop_pkg::bulk_beat_t)
  ) u_bulk_fifo (
    .usb_clock(usb_clock),
    .usb_reset(usb_reset),
    .valid_i  (fifo_wr_valid),
    .ready_o  (s_ready_o),
    .data_i   (wr_beat),
    .valid_o  (m_valid_o),
    .ready_i  (fifo_rd_ready),
    .data_o   (rd_beat),
    .level_o  (fifo_level)
  );

  bulk_ready_flags u_ready_flags (
    .usb_clock   (usb_clock),
    .usb_reset   (usb_reset),
    .configured_i(configured_i),
    .level_i     (fifo_level),
    .in_ready_o  (blk_in_ready_o),
    .out_ready_o (blk_out_ready_o)
  );

  // Either direction ready lights the activity LED
  assign bulk_activity = blk_in_ready_o || blk_out_ready_o;

  usb_status_leds u_status_leds (
    .usb_clock (usb_clock),
    .usb_reset (usb_reset),
    .sof_i     (sof_i),
    .crc_err_i (crc_err_i),
    .timeout_i (timeout_i),
    .activity_i(bulk_activity),
    .leds_o    (leds_o)
  );

endmodule

// File: usb_status_leds.sv
`timescale 1ns/10ps
`include "usb_loop_macros.svh"

module usb_status_leds (
  input  logic       usb_clock,
  input  logic       usb_reset,

  input  logic       sof_i,
  input  logic       crc_err_i,
  input  logic       timeout_i,
  input  logic       activity_i,

  output logic [5:0] leds_o
);

  logic                        sof_q;
  logic                        sof_prev_q;
  logic [`SOF_COUNT_BITS-1:0]  sof_count_q;
  logic                        crc_latch_q;
  logic                        timeout_latch_q;
  logic                        sof_rise;
  logic                        blink;

  // Register sof first, then look for the rising edge
  always_ff @(posedge usb_clock) begin
    if (usb_reset) begin
      sof_q      <= 1'b0;
      sof_prev_q <= 1'b0;
    end else begin
      sof_q      <= sof_i;
      sof_prev_q <= sof_q;
    end
  end

  assign sof_rise = sof_q && !sof_prev_q;

  always_ff @(posedge usb_clock) begin
    if (usb_reset) begin
      sof_count_q <= '0;
    end else if (sof_rise) begin
      sof_count_q <= sof_count_q + 1'b1;
    end
  end

  // Sticky error flags, cleared only by reset
  always_ff @(posedge usb_clock) begin
    if (usb_reset) begin
      crc_latch_q     <= 1'b0;
      timeout_latch_q <= 1'b0;
    end else begin
      if (crc_err_i) begin
        crc_latch_q <= 1'b1;
      end
      if (timeout_i) begin
        timeout_latch_q <= 1'b1;
      end
    end
  end

  // Short flashes once a CRC error has been seen
  assign blink = crc_latch_q ?
                 (sof_count_q[`ERR_BLINK_LO] & sof_count_q[`ERR_BLINK_LO + 1]) :
                 sof_count_q[`BLINK_BIT];

  // LEDs are active low, the two lowest are not used
  always_ff @(posedge usb_clock) begin
    if (usb_reset) begin
      leds_o <= 6'b111111;
    end else begin
      leds_o <= {~blink, ~timeout_latch_q, ~crc_latch_q, ~activity_i, 2'b11};
    end
  end

endmodule

// File: bulk_ready_flags.sv
`timescale 1ns/10ps
`include "usb_loop_macros.svh"

module bulk_ready_flags (
  input  logic                      usb_clock,
  input  logic                      usb_reset,

  input  logic                      configured_i,
  input  usb_loop_pkg::fifo_level_t level_i,

  output logic                      in_ready_o,
  output logic                      out_ready_o
);

  logic in_ready_d;
  logic out_ready_d;

  // Hold back IN until a few bytes are queued,
  // so a nearly empty FIFO does not produce a short packet
  assign in_ready_d = configured_i &&
                      (level_i > usb_loop_pkg::fifo_level_t'(`IN_READY_MIN));

  // Accept OUT only while a whole high-speed packet still fits
  assign out_ready_d = configured_i &&
                       (level_i < usb_loop_pkg::fifo_level_t'(`OUT_READY_MAX));

  always_ff @(posedge usb_clock) begin
    if (usb_reset) begin
      in_ready_o  <= 1'b0;
      out_ready_o <= 1'b0;
    end else begin
      in_ready_o  <= in_ready_d;
      out_ready_o <= out_ready_d;
    end
  end

endmodule

// File: sync_fifo.sv
`timescale 1ns/10ps
`include "usb_loop_macros.svh"

module sync_fifo #(
  parameter type payload_t = usb_loop_pkg::bulk_beat_t
) (
  input  logic                     usb_clock,
  input  logic                     usb_reset,

  input  logic                     valid_i,
  output logic                     ready_o,
  input  payload_t                 data_i,

  output logic                     valid_o,
  input  logic                     ready_i,
  output payload_t                 data_o,

  output usb_loop_pkg::fifo_level_t level_o
);

  localparam int DEPTH = 1 << `FIFO_ABITS;

  payload_t mem [DEPTH];
  payload_t out_q;

  logic [`FIFO_ABITS-1:0] wr_ptr_q;
  logic [`FIFO_ABITS-1:0] rd_ptr_q;
  logic                   out_valid_q;
  usb_loop_pkg::fifo_level_t count_q;

  logic wr_fire;
  logic rd_fire;
  logic mem_empty;
  logic out_load;
  logic bypass;
  logic mem_write;

  assign wr_fire   = valid_i && ready_o;
  assign rd_fire   = out_valid_q && ready_i;

  // Memory never holds more than DEPTH-1, so equal pointers mean empty
  assign mem_empty = (wr_ptr_q == rd_ptr_q);

  // Output register can take a new beat this edge
  assign out_load  = !out_valid_q || rd_fire;

  // Empty FIFO, write goes straight to the output register
  assign bypass    = out_load && mem_empty && wr_fire;
  assign mem_write = wr_fire && !bypass;

  assign ready_o = (count_q != usb_loop_pkg::fifo_level_t'(DEPTH));
  assign valid_o = out_valid_q;
  assign data_o  = out_q;
  assign level_o = count_q;

  always_ff @(posedge usb_clock) begin
    if (usb_reset) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      out_valid_q <= 1'b0;
      count_q     <= '0;
    end else begin
      if (mem_write) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end

      if (out_load) begin
        if (!mem_empty) begin
          rd_ptr_q    <= rd_ptr_q + 1'b1;
          out_valid_q <= 1'b1;
        end else begin
          out_valid_q <= wr_fire;
        end
      end

      // Count covers the memory and the output register
      case ({wr_fire, rd_fire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Payload storage
  always_ff @(posedge usb_clock) begin
    if (mem_write) begin
      mem[wr_ptr_q] <= data_i;
    end

    if (out_load) begin
      if (!mem_empty) begin
        out_q <= mem[rd_ptr_q];
      end else if (wr_fire) begin
        out_q <= data_i;
      end
    end
  end

endmodule

// File: usb_loop_pkg.sv
`include "usb_loop_macros.svh"

package usb_loop_pkg;

  // One byte on the bulk data path
  typedef logic [7:0] usb_byte_t;

  // Beat as stored in the loopback FIFO
  typedef struct packed {
    logic      last;
    usb_byte_t data;
  } bulk_beat_t;

  // One extra bit so that a full FIFO can be counted
  typedef logic [`FIFO_ABITS:0] fifo_level_t;

endpackage

// File: usb_loop_macros.svh
`ifndef USB_LOOP_MACROS_SVH
`define USB_LOOP_MACROS_SVH

// FIFO address bits, 2048 entries
`define FIFO_ABITS 11

// IN packet offered only once the level is above this
`define IN_READY_MIN 4

// OUT packet accepted only while the level is below this,
// leaves room for a full high-speed packet
`define OUT_READY_MAX 1024

// Start-of-frame count bits that drive the blink
`define BLINK_BIT 12
`define ERR_BLINK_LO 10

// Start-of-frame counter width
`define SOF_COUNT_BITS 24

`endif
